// ==== logic/riscv_v_pkg.sv ====
/*
 * Vector unit shared definitions
 * Geometry, stage latencies, data and address types and the opcode set
 */
`default_nettype none

package riscv_v_pkg;

    // Geometry
    localparam int riscv_v_elem_w        = 32;
    localparam int riscv_v_num_elem      = 4;
    localparam int riscv_v_num_regs      = 32;
    localparam int riscv_v_num_mask_regs = 4;

    // Pipeline distances in register stages
    localparam int riscv_v_id_2_exe_latency  = 1;
    localparam int riscv_v_exe_2_mem_latency = 1;
    localparam int riscv_v_exe_2_wb_latency  = 2;
    localparam int riscv_v_id_2_mem_latency  = 2;
    localparam int riscv_v_id_2_wb_latency   = 3;

    typedef logic [riscv_v_elem_w*riscv_v_num_elem-1:0]    riscv_v_data_t;
    typedef logic [riscv_v_elem_w-1:0]                     riscv_data_t;
    typedef logic [$clog2(riscv_v_num_regs)-1:0]           riscv_v_rf_addr_t;
    typedef logic [$clog2(riscv_v_num_mask_regs)-1:0]      riscv_v_mask_rf_addr_t;
    typedef logic [riscv_v_num_elem-1:0]                   riscv_v_mask_t;
    typedef logic [riscv_v_num_elem-1:0]                   riscv_v_rf_wr_en_t;

    typedef enum logic [3:0] {
        op_vadd    = 4'd0,
        op_vsub    = 4'd1,
        op_vand    = 4'd2,
        op_vor     = 4'd3,
        op_vxor    = 4'd4,
        op_vadd_vx = 4'd5,   // vs1 element plus scalar
        op_vmseq   = 4'd6,   // writes a mask register
        op_vext_xv = 4'd7    // writes the scalar core
    } riscv_v_op_e;

endpackage : riscv_v_pkg

`default_nettype wire

// ==== logic/riscv_v_stage.sv ====
/*
 * Generic pipeline delay line
 * num_stages stall-frozen registers with reset and flush values, all taps visible
 */
`default_nettype none

module riscv_v_stage #(
    parameter type data_t     = logic,
    parameter int  num_stages = 1
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  en,
    input  logic  flush,
    input  data_t rst_val,
    input  data_t flush_val,
    input  data_t data_in,
    output data_t data_out,
    output data_t internal_data [num_stages:0]
);

    data_t regs [num_stages];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_stages; i++) begin
                regs[i] <= rst_val;
            end
        end else if (en) begin
            regs[0] <= flush ? flush_val : data_in;
            for (int i = 1; i < num_stages; i++) begin
                regs[i] <= flush ? flush_val : regs[i-1];
            end
        end
    end

    // Tap 0 is the input itself
    assign internal_data[0] = data_in;

    for (genvar i = 0; i < num_stages; i++) begin : g_tap
        assign internal_data[i+1] = regs[i];
    end

    assign data_out = regs[num_stages-1];

endmodule : riscv_v_stage

`default_nettype wire

// ==== logic/riscv_v_rf_ctrl.sv ====
/*
 * Vector register file staging controller
 * Carries addresses, enables and data from ID or EXE through MEM to WB
 */
`default_nettype none

module riscv_v_rf_ctrl (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               stall,
    input  logic                               flush,
    // Vector register file
    input  riscv_v_pkg::riscv_v_rf_addr_t      rf_wr_addr_id,
    output riscv_v_pkg::riscv_v_rf_addr_t      rf_wr_addr_mem,
    output riscv_v_pkg::riscv_v_rf_addr_t      rf_wr_addr_wb,
    input  riscv_v_pkg::riscv_v_rf_wr_en_t     rf_wr_en_exe,
    output riscv_v_pkg::riscv_v_rf_wr_en_t     rf_wr_en_mem,
    output riscv_v_pkg::riscv_v_rf_wr_en_t     rf_wr_en_wb,
    input  riscv_v_pkg::riscv_v_data_t         rf_wr_data_exe,
    output riscv_v_pkg::riscv_v_data_t         rf_wr_data_mem,
    output riscv_v_pkg::riscv_v_data_t         rf_wr_data_wb,
    input  riscv_v_pkg::riscv_v_data_t         rf_rd_data_srca_id,
    output riscv_v_pkg::riscv_v_data_t         rf_rd_data_srca_exe,
    input  riscv_v_pkg::riscv_v_data_t         rf_rd_data_srcb_id,
    output riscv_v_pkg::riscv_v_data_t         rf_rd_data_srcb_exe,
    // Mask register file
    input  riscv_v_pkg::riscv_v_mask_rf_addr_t mask_rf_wr_addr_id,
    output riscv_v_pkg::riscv_v_mask_rf_addr_t mask_rf_wr_addr_wb,
    input  riscv_v_pkg::riscv_v_mask_t         mask_rf_wr_data_exe,
    output riscv_v_pkg::riscv_v_mask_t         mask_rf_wr_data_wb,
    input  logic                               mask_rf_wr_en_id,
    output logic                               mask_rf_wr_en_wb,
    input  riscv_v_pkg::riscv_v_mask_t         mask_rf_rd_data_id,
    output riscv_v_pkg::riscv_v_mask_t         mask_rf_rd_data_exe,
    // Scalar register file of the core
    input  riscv_v_pkg::riscv_data_t           int_rf_rd_data_id,
    output riscv_v_pkg::riscv_data_t           int_rf_rd_data_exe,
    input  riscv_v_pkg::riscv_data_t           int_rf_wr_data_exe,
    output riscv_v_pkg::riscv_data_t           int_rf_wr_data_wb,
    input  logic                               int_rf_wr_en_id,
    output logic                               int_rf_wr_en_wb
);

    localparam int id_exe  = riscv_v_pkg::riscv_v_id_2_exe_latency;
    localparam int id_wb   = riscv_v_pkg::riscv_v_id_2_wb_latency;
    localparam int exe_wb  = riscv_v_pkg::riscv_v_exe_2_wb_latency;

    logic en_stage;

    riscv_v_pkg::riscv_v_rf_addr_t  rf_wr_addr_stages [id_wb:0];
    riscv_v_pkg::riscv_v_rf_wr_en_t rf_wr_en_stages   [exe_wb:0];
    riscv_v_pkg::riscv_v_data_t     rf_wr_data_stages [exe_wb:0];

    assign en_stage = ~stall;

    // Only the enable chains see reset and flush
    riscv_v_stage #(.data_t(riscv_v_pkg::riscv_v_rf_addr_t), .num_stages(id_wb)) stage_rf_wr_addr (
        .clk, .rst_n(1'b1), .en(en_stage), .flush(1'b0), .rst_val('0), .flush_val('0),
        .data_in(rf_wr_addr_id), .data_out(rf_wr_addr_wb), .internal_data(rf_wr_addr_stages));
    riscv_v_stage #(.data_t(riscv_v_pkg::riscv_v_rf_wr_en_t), .num_stages(exe_wb)) stage_rf_wr_en (
        .clk, .rst_n, .en(en_stage), .flush, .rst_val('0), .flush_val('0),
        .data_in(rf_wr_en_exe), .data_out(rf_wr_en_wb), .internal_data(rf_wr_en_stages));
    riscv_v_stage #(.data_t(riscv_v_pkg::riscv_v_data_t), .num_stages(exe_wb)) stage_rf_wr_data (
        .clk, .rst_n(1'b1), .en(en_stage), .flush(1'b0), .rst_val('0), .flush_val('0),
        .data_in(rf_wr_data_exe), .data_out(rf_wr_data_wb), .internal_data(rf_wr_data_stages));
    riscv_v_stage #(.data_t(riscv_v_pkg::riscv_v_data_t), .num_stages(id_exe)) stage_srca (
        .clk, .rst_n(1'b1), .en(en_stage), .flush(1'b0), .rst_val('0), .flush_val('0),
        .data_in(rf_rd_data_srca_id), .data_out(rf_rd_data_srca_exe), .internal_data());
    riscv_v_stage #(.data_t(riscv_v_pkg::riscv_v_data_t), .num_stages(id_exe)) stage_srcb (
        .clk, .rst_n(1'b1), .en(en_stage), .flush(1'b0), .rst_val('0), .flush_val('0),
        .data_in(rf_rd_data_srcb_id), .data_out(rf_rd_data_srcb_exe), .internal_data());

    // Mask register file
    riscv_v_stage #(.data_t(riscv_v_pkg::riscv_v_mask_rf_addr_t), .num_stages(id_wb)) stage_mask_addr (
        .clk, .rst_n(1'b1), .en(en_stage), .flush(1'b0), .rst_val('0), .flush_val('0),
        .data_in(mask_rf_wr_addr_id), .data_out(mask_rf_wr_addr_wb), .internal_data());
    riscv_v_stage #(.data_t(riscv_v_pkg::riscv_v_mask_t), .num_stages(exe_wb)) stage_mask_wr_data (
        .clk, .rst_n(1'b1), .en(en_stage), .flush(1'b0), .rst_val('0), .flush_val('0),
        .data_in(mask_rf_wr_data_exe), .data_out(mask_rf_wr_data_wb), .internal_data());
    riscv_v_stage #(.data_t(logic), .num_stages(id_wb)) stage_mask_wr_en (
        .clk, .rst_n, .en(en_stage), .flush, .rst_val('0), .flush_val('0),
        .data_in(mask_rf_wr_en_id), .data_out(mask_rf_wr_en_wb), .internal_data());
    riscv_v_stage #(.data_t(riscv_v_pkg::riscv_v_mask_t), .num_stages(id_exe)) stage_mask_rd_data (
        .clk, .rst_n(1'b1), .en(en_stage), .flush(1'b0), .rst_val('0), .flush_val('0),
        .data_in(mask_rf_rd_data_id), .data_out(mask_rf_rd_data_exe), .internal_data());

    // Scalar register file
    riscv_v_stage #(.data_t(riscv_v_pkg::riscv_data_t), .num_stages(id_exe)) stage_int_rd_data (
        .clk, .rst_n(1'b1), .en(en_stage), .flush(1'b0), .rst_val('0), .flush_val('0),
        .data_in(int_rf_rd_data_id), .data_out(int_rf_rd_data_exe), .internal_data());
    riscv_v_stage #(.data_t(riscv_v_pkg::riscv_data_t), .num_stages(exe_wb)) stage_int_wr_data (
        .clk, .rst_n(1'b1), .en(en_stage), .flush(1'b0), .rst_val('0), .flush_val('0),
        .data_in(int_rf_wr_data_exe), .data_out(int_rf_wr_data_wb), .internal_data());
    riscv_v_stage #(.data_t(logic), .num_stages(id_wb)) stage_int_wr_en (
        .clk, .rst_n, .en(en_stage), .flush, .rst_val('0), .flush_val('0),
        .data_in(int_rf_wr_en_id), .data_out(int_rf_wr_en_wb), .internal_data());

    // MEM view for an outside hazard unit
    assign rf_wr_addr_mem = rf_wr_addr_stages[riscv_v_pkg::riscv_v_id_2_mem_latency];
    assign rf_wr_en_mem   = rf_wr_en_stages[riscv_v_pkg::riscv_v_exe_2_mem_latency];
    assign rf_wr_data_mem = rf_wr_data_stages[riscv_v_pkg::riscv_v_exe_2_mem_latency];

endmodule : riscv_v_rf_ctrl

`default_nettype wire

// ==== logic/riscv_v_rf.sv ====
/*
 * Vector register file
 * Two combinational read ports, one write port with per-element enables
 */
`default_nettype none

module riscv_v_rf (
    input  logic                           clk,
    input  riscv_v_pkg::riscv_v_rf_addr_t  rd_addr_a,
    input  riscv_v_pkg::riscv_v_rf_addr_t  rd_addr_b,
    output riscv_v_pkg::riscv_v_data_t     rd_data_a,
    output riscv_v_pkg::riscv_v_data_t     rd_data_b,
    input  riscv_v_pkg::riscv_v_rf_addr_t  wr_addr,
    input  riscv_v_pkg::riscv_v_rf_wr_en_t wr_en,
    input  riscv_v_pkg::riscv_v_data_t     wr_data
);

    localparam int elem_w = riscv_v_pkg::riscv_v_elem_w;

    riscv_v_pkg::riscv_v_data_t regs [riscv_v_pkg::riscv_v_num_regs];

    always_ff @(posedge clk) begin
        for (int i = 0; i < riscv_v_pkg::riscv_v_num_elem; i++) begin
            if (wr_en[i]) begin
                regs[wr_addr][i*elem_w +: elem_w] <= wr_data[i*elem_w +: elem_w];
            end
        end
    end

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule : riscv_v_rf

`default_nettype wire

// ==== logic/riscv_v_mask_rf.sv ====
/*
 * Mask register file
 * One combinational read port and one clocked write port
 */
`default_nettype none

module riscv_v_mask_rf (
    input  logic                               clk,
    input  riscv_v_pkg::riscv_v_mask_rf_addr_t rd_addr,
    output riscv_v_pkg::riscv_v_mask_t         rd_data,
    input  riscv_v_pkg::riscv_v_mask_rf_addr_t wr_addr,
    input  logic                               wr_en,
    input  riscv_v_pkg::riscv_v_mask_t         wr_data
);

    riscv_v_pkg::riscv_v_mask_t regs [riscv_v_pkg::riscv_v_num_mask_regs];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data = regs[rd_addr];

endmodule : riscv_v_mask_rf

`default_nettype wire

// ==== logic/riscv_v_valu.sv ====
/*
 * Vector ALU
 * Decodes write enables at ID, computes vector, mask and scalar results in EXE
 */
`default_nettype none

module riscv_v_valu (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            stall,
    input  logic                            flush,
    input  logic                            issue_valid,
    input  riscv_v_pkg::riscv_v_op_e        op,
    input  logic                            vm,
    input  riscv_v_pkg::riscv_v_mask_t      mask_rd_data_id,
    input  riscv_v_pkg::riscv_v_data_t      srca_exe,
    input  riscv_v_pkg::riscv_v_data_t      srcb_exe,
    input  riscv_v_pkg::riscv_data_t        scalar_exe,
    output logic                            mask_rf_wr_en_id,
    output logic                            int_rf_wr_en_id,
    output riscv_v_pkg::riscv_v_rf_wr_en_t  rf_wr_en_exe,
    output riscv_v_pkg::riscv_v_data_t      rf_wr_data_exe,
    output riscv_v_pkg::riscv_v_mask_t      mask_rf_wr_data_exe,
    output riscv_v_pkg::riscv_data_t        int_rf_wr_data_exe
);

    localparam int elem_w = riscv_v_pkg::riscv_v_elem_w;

    riscv_v_pkg::riscv_v_op_e       op_exe;
    logic                           valid_exe;
    riscv_v_pkg::riscv_v_rf_wr_en_t elem_en_id;
    riscv_v_pkg::riscv_v_rf_wr_en_t elem_en_exe;
    logic                           vec_wr_exe;

    assign mask_rf_wr_en_id = issue_valid && (op == riscv_v_pkg::op_vmseq);
    assign int_rf_wr_en_id  = issue_valid && (op == riscv_v_pkg::op_vext_xv);
    assign elem_en_id       = vm ? '1 : mask_rd_data_id;

    riscv_v_stage #(.data_t(riscv_v_pkg::riscv_v_op_e), .num_stages(1)) stage_op (
        .clk, .rst_n(1'b1), .en(~stall), .flush(1'b0),
        .rst_val(riscv_v_pkg::op_vadd), .flush_val(riscv_v_pkg::op_vadd),
        .data_in(op), .data_out(op_exe), .internal_data());
    riscv_v_stage #(.data_t(logic), .num_stages(1)) stage_valid (
        .clk, .rst_n, .en(~stall), .flush, .rst_val(1'b0), .flush_val(1'b0),
        .data_in(issue_valid), .data_out(valid_exe), .internal_data());
    riscv_v_stage #(.data_t(riscv_v_pkg::riscv_v_rf_wr_en_t), .num_stages(1)) stage_elem_en (
        .clk, .rst_n, .en(~stall), .flush, .rst_val('0), .flush_val('0),
        .data_in(elem_en_id), .data_out(elem_en_exe), .internal_data());

    // Compare and extract never touch the vector file
    assign vec_wr_exe   = valid_exe && (op_exe != riscv_v_pkg::op_vmseq) &&
                          (op_exe != riscv_v_pkg::op_vext_xv);
    assign rf_wr_en_exe = vec_wr_exe ? elem_en_exe : '0;

    always_comb begin
        riscv_v_pkg::riscv_data_t a;
        riscv_v_pkg::riscv_data_t b;
        for (int i = 0; i < riscv_v_pkg::riscv_v_num_elem; i++) begin
            a = srca_exe[i*elem_w +: elem_w];
            b = srcb_exe[i*elem_w +: elem_w];
            mask_rf_wr_data_exe[i] = (a == b);
            case (op_exe)
                riscv_v_pkg::op_vadd:    rf_wr_data_exe[i*elem_w +: elem_w] = a + b;
                riscv_v_pkg::op_vsub:    rf_wr_data_exe[i*elem_w +: elem_w] = a - b;
                riscv_v_pkg::op_vand:    rf_wr_data_exe[i*elem_w +: elem_w] = a & b;
                riscv_v_pkg::op_vor:     rf_wr_data_exe[i*elem_w +: elem_w] = a | b;
                riscv_v_pkg::op_vxor:    rf_wr_data_exe[i*elem_w +: elem_w] = a ^ b;
                riscv_v_pkg::op_vadd_vx: rf_wr_data_exe[i*elem_w +: elem_w] = a + scalar_exe;
                default:                 rf_wr_data_exe[i*elem_w +: elem_w] = a;
            endcase
        end
    end

    // Element index wraps on the vector length
    assign int_rf_wr_data_exe =
        srca_exe[(scalar_exe % riscv_v_pkg::riscv_v_num_elem) * elem_w +: elem_w];

endmodule : riscv_v_valu

`default_nettype wire

// ==== logic/riscv_v_rf_pipe.sv ====
/*
 * Vector register file pipeline
 * Register files, staging controller and ALU from ID to WB
 */
`default_nettype none

module riscv_v_rf_pipe (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               issue_valid,
    input  riscv_v_pkg::riscv_v_op_e           op,
    input  logic                               vm,
    input  riscv_v_pkg::riscv_v_rf_addr_t      vs1_addr,
    input  riscv_v_pkg::riscv_v_rf_addr_t      vs2_addr,
    input  riscv_v_pkg::riscv_v_rf_addr_t      vd_addr,
    input  riscv_v_pkg::riscv_v_mask_rf_addr_t mask_src_addr,
    input  riscv_v_pkg::riscv_v_mask_rf_addr_t mask_dst_addr,
    input  riscv_v_pkg::riscv_data_t           int_rf_rd_data,
    input  logic                               stall,
    input  logic                               flush,
    output logic                               int_rf_wr_en,
    output riscv_v_pkg::riscv_data_t           int_rf_wr_data,
    output riscv_v_pkg::riscv_v_rf_addr_t      vd_addr_mem,
    output riscv_v_pkg::riscv_v_rf_wr_en_t     vd_wr_en_mem
);

    riscv_v_pkg::riscv_v_data_t         srca_id;
    riscv_v_pkg::riscv_v_data_t         srcb_id;
    riscv_v_pkg::riscv_v_mask_t         mask_rd_data_id;
    riscv_v_pkg::riscv_v_data_t         srca_exe;
    riscv_v_pkg::riscv_v_data_t         srcb_exe;
    riscv_v_pkg::riscv_data_t           scalar_exe;
    logic                               mask_wr_en_id;
    logic                               int_wr_en_id;
    riscv_v_pkg::riscv_v_rf_wr_en_t     rf_wr_en_exe;
    riscv_v_pkg::riscv_v_data_t         rf_wr_data_exe;
    riscv_v_pkg::riscv_v_mask_t         mask_wr_data_exe;
    riscv_v_pkg::riscv_data_t           int_wr_data_exe;
    riscv_v_pkg::riscv_v_rf_addr_t      rf_wr_addr_wb;
    riscv_v_pkg::riscv_v_rf_wr_en_t     rf_wr_en_wb;
    riscv_v_pkg::riscv_v_data_t         rf_wr_data_wb;
    riscv_v_pkg::riscv_v_mask_rf_addr_t mask_wr_addr_wb;
    riscv_v_pkg::riscv_v_mask_t         mask_wr_data_wb;
    logic                               mask_wr_en_wb;

    riscv_v_rf u_rf (
        .clk, .rd_addr_a(vs1_addr), .rd_addr_b(vs2_addr), .rd_data_a(srca_id),
        .rd_data_b(srcb_id), .wr_addr(rf_wr_addr_wb), .wr_en(rf_wr_en_wb),
        .wr_data(rf_wr_data_wb));

    riscv_v_mask_rf u_mask_rf (
        .clk, .rd_addr(mask_src_addr), .rd_data(mask_rd_data_id), .wr_addr(mask_wr_addr_wb),
        .wr_en(mask_wr_en_wb), .wr_data(mask_wr_data_wb));

    riscv_v_rf_ctrl u_rf_ctrl (
        .clk, .rst_n, .stall, .flush,
        .rf_wr_addr_id(vd_addr), .rf_wr_addr_mem(vd_addr_mem), .rf_wr_addr_wb,
        .rf_wr_en_exe, .rf_wr_en_mem(vd_wr_en_mem), .rf_wr_en_wb,
        .rf_wr_data_exe, .rf_wr_data_mem(), .rf_wr_data_wb,
        .rf_rd_data_srca_id(srca_id), .rf_rd_data_srca_exe(srca_exe),
        .rf_rd_data_srcb_id(srcb_id), .rf_rd_data_srcb_exe(srcb_exe),
        .mask_rf_wr_addr_id(mask_dst_addr), .mask_rf_wr_addr_wb(mask_wr_addr_wb),
        .mask_rf_wr_data_exe(mask_wr_data_exe), .mask_rf_wr_data_wb(mask_wr_data_wb),
        .mask_rf_wr_en_id(mask_wr_en_id), .mask_rf_wr_en_wb(mask_wr_en_wb),
        .mask_rf_rd_data_id(mask_rd_data_id), .mask_rf_rd_data_exe(),
        .int_rf_rd_data_id(int_rf_rd_data), .int_rf_rd_data_exe(scalar_exe),
        .int_rf_wr_data_exe(int_wr_data_exe), .int_rf_wr_data_wb(int_rf_wr_data),
        .int_rf_wr_en_id(int_wr_en_id), .int_rf_wr_en_wb(int_rf_wr_en));

    riscv_v_valu u_valu (
        .clk, .rst_n, .stall, .flush, .issue_valid, .op, .vm,
        .mask_rd_data_id, .srca_exe, .srcb_exe, .scalar_exe,
        .mask_rf_wr_en_id(mask_wr_en_id), .int_rf_wr_en_id(int_wr_en_id),
        .rf_wr_en_exe, .rf_wr_data_exe, .mask_rf_wr_data_exe(mask_wr_data_exe),
        .int_rf_wr_data_exe(int_wr_data_exe));

endmodule : riscv_v_rf_pipe

`default_nettype wire

// ==== test/riscv_v_rf_pipe_sva.sv ====
/*
 * Vector register file pipeline assertions
 * Reset, stall and flush behavior of the staged enables
 */
`default_nettype none

module riscv_v_rf_pipe_sva (
    input logic       clk,
    input logic       rst_n,
    input logic       stall,
    input logic       flush,
    input logic       int_rf_wr_en,
    input logic [3:0] vd_wr_en_mem
);

    timeunit 1ns;
    timeprecision 1ns;

    int fail_count = 0;

    a_reset_clears: assert property (@(posedge clk)
        !rst_n |=> (!int_rf_wr_en && vd_wr_en_mem == '0))
    else begin
        fail_count++;
        $error("MEM or WB enable set after a reset cycle");
    end

    // A stalled edge must leave every stage untouched
    a_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> ($stable(int_rf_wr_en) && $stable(vd_wr_en_mem)))
    else begin
        fail_count++;
        $error("Enable changed across a stalled edge");
    end

    a_flush_kills: assert property (@(posedge clk) disable iff (!rst_n)
        (flush && !stall) |=> (vd_wr_en_mem == '0))
    else begin
        fail_count++;
        $error("MEM element enable survived a flush");
    end

endmodule : riscv_v_rf_pipe_sva

`default_nettype wire

// ==== test/riscv_v_rf_pipe_tb.sv ====
/*
 * Vector register file pipeline testbench
 * Directed tests against a register model: ALU ops, masking, stall and flush
 */
`default_nettype none

module riscv_v_rf_pipe_tb;

    timeunit 1ns;
    timeprecision 1ns;

    localparam int ew         = riscv_v_pkg::riscv_v_elem_w;
    localparam int reset_len  = 12;
    localparam int alu_len    = 11 * 5 + 36 * 5;
    localparam int mask_len   = 4 * 5 + 8 * 5;
    localparam int stall_len  = 20;
    localparam int flush_len  = 10 + 4 * 5;
    localparam int cycle_limit = 2 * (reset_len + alu_len + mask_len + stall_len + flush_len);

    logic                               clk;
    logic                               rst_n;
    logic                               issue_valid;
    riscv_v_pkg::riscv_v_op_e           op;
    logic                               vm;
    riscv_v_pkg::riscv_v_rf_addr_t      vs1_addr;
    riscv_v_pkg::riscv_v_rf_addr_t      vs2_addr;
    riscv_v_pkg::riscv_v_rf_addr_t      vd_addr;
    riscv_v_pkg::riscv_v_mask_rf_addr_t mask_src_addr;
    riscv_v_pkg::riscv_v_mask_rf_addr_t mask_dst_addr;
    riscv_v_pkg::riscv_data_t           int_rf_rd_data;
    logic                               stall;
    logic                               flush;
    logic                               int_rf_wr_en;
    riscv_v_pkg::riscv_data_t           int_rf_wr_data;
    riscv_v_pkg::riscv_v_rf_addr_t      vd_addr_mem;
    riscv_v_pkg::riscv_v_rf_wr_en_t     vd_wr_en_mem;

    riscv_v_pkg::riscv_v_data_t vmodel [riscv_v_pkg::riscv_v_num_regs];
    riscv_v_pkg::riscv_v_mask_t mmodel [riscv_v_pkg::riscv_v_num_mask_regs];
    riscv_v_pkg::riscv_data_t   r [1:4];
    int errors = 0;
    int checks = 0;
    int cycle = 0;
    int total;

    riscv_v_rf_pipe DUT (.*);

    bind riscv_v_rf_pipe riscv_v_rf_pipe_sva u_sva (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush),
        .int_rf_wr_en(int_rf_wr_en), .vd_wr_en_mem(vd_wr_en_mem));

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("Timeout: no end of tests after %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check(input logic [127:0] actual, input logic [127:0] expected,
                         input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR @%0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // Reference behavior of one instruction and its element enables
    task automatic exec_model(input riscv_v_pkg::riscv_v_op_e opc, input logic vmb,
                              input int s1, input int s2, input int d, input int msrc,
                              input int mdst, input riscv_v_pkg::riscv_data_t sc,
                              output logic [3:0] en);
        logic [ew-1:0] a;
        logic [ew-1:0] b;
        logic [ew-1:0] res;
        logic [3:0]    eq;
        en = 4'h0;
        eq = 4'h0;
        if (opc != riscv_v_pkg::op_vmseq && opc != riscv_v_pkg::op_vext_xv) begin
            en = vmb ? 4'hf : mmodel[msrc];
        end
        for (int i = 0; i < riscv_v_pkg::riscv_v_num_elem; i++) begin
            a = vmodel[s1][i*ew +: ew];
            b = vmodel[s2][i*ew +: ew];
            eq[i] = (a == b);
            case (opc)
                riscv_v_pkg::op_vadd:    res = a + b;
                riscv_v_pkg::op_vsub:    res = a - b;
                riscv_v_pkg::op_vand:    res = a & b;
                riscv_v_pkg::op_vor:     res = a | b;
                riscv_v_pkg::op_vxor:    res = a ^ b;
                riscv_v_pkg::op_vadd_vx: res = a + sc;
                default:                 res = a;
            endcase
            if (en[i]) begin
                vmodel[d][i*ew +: ew] = res;
            end
        end
        if (opc == riscv_v_pkg::op_vmseq) begin
            mmodel[mdst] = eq;
        end
    endtask

    task automatic present(input riscv_v_pkg::riscv_v_op_e opc, input logic vmb, input int s1,
                           input int s2, input int d, input int msrc, input int mdst,
                           input riscv_v_pkg::riscv_data_t sc);
        @(posedge clk);
        issue_valid    <= 1'b1;
        op             <= opc;
        vm             <= vmb;
        vs1_addr       <= s1;
        vs2_addr       <= s2;
        vd_addr        <= d;
        mask_src_addr  <= msrc;
        mask_dst_addr  <= mdst;
        int_rf_rd_data <= sc;
    endtask

    // Returns at the accepting edge t
    task automatic issue(input riscv_v_pkg::riscv_v_op_e opc, input logic vmb, input int s1,
                         input int s2, input int d, input int msrc, input int mdst,
                         input riscv_v_pkg::riscv_data_t sc);
        present(opc, vmb, s1, s2, d, msrc, mdst, sc);
        @(posedge clk);
        issue_valid <= 1'b0;
    endtask

    task automatic run_op(input riscv_v_pkg::riscv_v_op_e opc, input logic vmb, input int s1,
                          input int s2, input int d, input int msrc, input int mdst,
                          input riscv_v_pkg::riscv_data_t sc);
        logic [3:0] en;
        exec_model(opc, vmb, s1, s2, d, msrc, mdst, sc, en);
        issue(opc, vmb, s1, s2, d, msrc, mdst, sc);
        @(negedge clk);
        @(negedge clk);
        check(vd_wr_en_mem, en, $sformatf("MEM element enable of %s", opc.name()));
        if (en != 4'h0) begin
            check(vd_addr_mem, d, "MEM destination address");
        end
        // Next issue lands after the write edge t+3
        @(posedge clk);
    endtask

    task automatic read_elem(input int s1, input riscv_v_pkg::riscv_data_t idx,
                             input int stall_cycles);
        riscv_v_pkg::riscv_data_t expected;
        int waited;
        expected = vmodel[s1][(idx % 4) * ew +: ew];
        waited = 0;
        issue(riscv_v_pkg::op_vext_xv, 1'b1, s1, 0, 0, 0, 0, idx);
        fork
            begin
                if (stall_cycles > 0) begin
                    stall <= 1'b1;
                    repeat (stall_cycles) @(posedge clk);
                    stall <= 1'b0;
                end
            end
            begin
                do begin
                    @(negedge clk);
                    waited++;
                end while (!int_rf_wr_en && waited < 20 + stall_cycles);
            end
        join
        check(waited, 3 + stall_cycles, "scalar write cycles after issue");
        check(int_rf_wr_data, expected, $sformatf("v%0d element %0d", s1, idx % 4));
        @(negedge clk);
        check(int_rf_wr_en, 1'b0, "scalar write repeated");
    endtask

    task automatic test_reset();
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            if (i == 9) begin
                rst_n <= 1'b1;
            end
            @(negedge clk);
            check(int_rf_wr_en, 1'b0, "scalar write enable in reset");
            check(vd_wr_en_mem, 4'h0, "MEM enable in reset");
        end
        @(negedge clk);
        check(int_rf_wr_en, 1'b0, "scalar write enable after reset");
        check(vd_wr_en_mem, 4'h0, "MEM enable after reset");
    endtask

    task automatic test_alu();
        run_op(riscv_v_pkg::op_vxor, 1'b1, 0, 0, 0, 0, 0, 0);
        for (int i = 1; i <= 4; i++) begin
            run_op(riscv_v_pkg::op_vadd_vx, 1'b1, 0, 0, i, 0, 0, r[i]);
        end
        run_op(riscv_v_pkg::op_vadd, 1'b1, 1, 2, 5, 0, 0, 0);
        run_op(riscv_v_pkg::op_vsub, 1'b1, 1, 2, 6, 0, 0, 0);
        run_op(riscv_v_pkg::op_vand, 1'b1, 3, 4, 7, 0, 0, 0);
        run_op(riscv_v_pkg::op_vor, 1'b1, 3, 4, 8, 0, 0, 0);
        run_op(riscv_v_pkg::op_vxor, 1'b1, 3, 4, 9, 0, 0, 0);
        run_op(riscv_v_pkg::op_vadd_vx, 1'b1, 5, 0, 5, 0, 0, $urandom);
        for (int v = 1; v <= 9; v++) begin
            for (int e = 0; e < 4; e++) begin
                // Index above 3 exercises the wrap
                read_elem(v, e + 4 * ($urandom % 3), 0);
            end
        end
    endtask

    task automatic test_mask();
        run_op(riscv_v_pkg::op_vmseq, 1'b1, 1, 1, 0, 0, 1, 0);
        run_op(riscv_v_pkg::op_vmseq, 1'b1, 1, 2, 0, 0, 2, 0);
        run_op(riscv_v_pkg::op_vadd, 1'b0, 3, 4, 7, 2, 0, 0);
        run_op(riscv_v_pkg::op_vadd, 1'b0, 3, 4, 8, 1, 0, 0);
        for (int e = 0; e < 4; e++) begin
            read_elem(7, e, 0);
            read_elem(8, e, 0);
        end
    endtask

    task automatic test_stall();
        read_elem(3, 2, 2 + $urandom % 7);
    endtask

    task automatic test_flush();
        present(riscv_v_pkg::op_vext_xv, 1'b1, 1, 0, 0, 0, 0, 0);
        // Vector write sits in EXE in the flush cycle
        present(riscv_v_pkg::op_vadd_vx, 1'b1, 0, 0, 5, 0, 0, 77);
        // Third instruction sits at ID in the flush cycle
        present(riscv_v_pkg::op_vadd_vx, 1'b1, 0, 0, 6, 0, 0, 99);
        flush <= 1'b1;
        @(posedge clk);
        issue_valid <= 1'b0;
        flush <= 1'b0;
        repeat (6) begin
            @(negedge clk);
            check(int_rf_wr_en, 1'b0, "scalar write after flush");
        end
        read_elem(5, 0, 0);
        read_elem(5, 3, 0);
        read_elem(6, 1, 0);
        read_elem(6, 2, 0);
    endtask

    initial begin
        void'($urandom(81906));
        rst_n          = 1'b0;
        issue_valid    = 1'b0;
        op             = riscv_v_pkg::op_vadd;
        vm             = 1'b1;
        vs1_addr       = '0;
        vs2_addr       = '0;
        vd_addr        = '0;
        mask_src_addr  = '0;
        mask_dst_addr  = '0;
        int_rf_rd_data = '0;
        stall          = 1'b0;
        flush          = 1'b0;
        for (int i = 0; i < riscv_v_pkg::riscv_v_num_regs; i++) begin
            vmodel[i] = '0;
        end
        for (int i = 0; i < riscv_v_pkg::riscv_v_num_mask_regs; i++) begin
            mmodel[i] = '0;
        end
        for (int i = 1; i <= 4; i++) begin
            r[i] = $urandom;
        end
        // Unequal sources give an all-clear compare mask
        r[2] = r[1] + 1;

        test_reset();
        test_alu();
        test_mask();
        test_stall();
        test_flush();

        total = errors + DUT.u_sva.fail_count;
        $display("Checks: %0d, errors: %0d", checks, total);
        if (total == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : riscv_v_rf_pipe_tb

`default_nettype wire

// ==== riscv_v.f ====
logic/riscv_v_pkg.sv
logic/riscv_v_stage.sv
logic/riscv_v_rf_ctrl.sv
logic/riscv_v_rf.sv
logic/riscv_v_mask_rf.sv
logic/riscv_v_valu.sv
logic/riscv_v_rf_pipe.sv
test/riscv_v_rf_pipe_sva.sv
test/riscv_v_rf_pipe_tb.sv

// ==== Makefile ====
# Verilator build and run of the vector register file pipeline testbench

SIM      := verilator
TOP      := riscv_v_rf_pipe_tb
FILELIST := riscv_v.f
FLAGS    := --binary --timing --assert -Wno-fatal
RUNFLAGS := +verilator+error+limit+100
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
